// ==== design/VideoTimingPkg.sv ====
// Fixed timing of the small RGB panel, no runtime configuration
// Counter widths assume the active phase is the longest on each axis
`default_nettype none

package VideoTimingPkg;

	// --------------------------------------------------
	// Horizontal timing in pixel clocks
	// --------------------------------------------------
	localparam int lpVHA = 16;	// Active
	localparam int lpVHB = 4;	// Back porch
	localparam int lpVHF = 2;	// Front porch
	localparam int lpVHS = 3;	// Sync

	// --------------------------------------------------
	// Vertical timing in lines
	// --------------------------------------------------
	localparam int lpVVA = 8;
	localparam int lpVVB = 2;
	localparam int lpVVF = 2;
	localparam int lpVVS = 2;

	localparam int lpHCntW = $clog2(lpVHA);	// Phase counter widths
	localparam int lpVCntW = $clog2(lpVVA);
	localparam int lpPosW = 8;

	// Sync generator held off this long after reset
	localparam int lpRstWait = 128;
	localparam int lpRstWaitW = $clog2(lpRstWait + 1);

	localparam int lpPixLatency = 2;	// Pixel pipeline depth

	// Same phase order on both axes
	typedef enum logic [1:0] {phSync, phBack, phActive, phFront} SyncPhase;

endpackage

`default_nettype wire

// ==== design/VideoCsrPkg.sv ====
// Register map of the video block, byte addresses, 32-bit aligned words only
`default_nettype none

package VideoCsrPkg;

	// Bus and payload widths
	localparam int lpAxiAdrsW = 8;
	localparam int lpAxiDataW = 32;
	localparam int lpColorW = 24;
	localparam int lpRectNum = 4;
	localparam int lpRectIdxW = $clog2(lpRectNum);
	localparam int lpFrameCntW = 16;

	// --------------------------------------------------
	// Byte offsets
	// --------------------------------------------------
	localparam logic [lpAxiAdrsW-1:0] lpAdrsCtrl = 8'h00;
	localparam logic [lpAxiAdrsW-1:0] lpAdrsBg = 8'h04;
	localparam logic [lpAxiAdrsW-1:0] lpAdrsRectBase = 8'h10;	// Bounds +8n, colour +8n+4
	localparam logic [lpAxiAdrsW-1:0] lpAdrsFrameCnt = 8'h40;

	localparam logic [lpColorW-1:0] lpBgReset = 24'h000000;
	localparam logic [lpAxiDataW-1:0] lpBoundsReset = 32'h0000_0000;
	// Zero bounds still cover pixel (0,0)
	localparam logic [lpColorW-1:0] lpRectColorReset = 24'h000000;

	// Register select decoded from the address
	typedef enum logic [2:0] {selCtrl, selBg, selBounds, selColor, selFrameCnt, selNone} CsrSel;

	typedef enum logic [1:0] {respOkay = 2'd0, respSlvErr = 2'd2} AxiResp;

endpackage

`default_nettype wire

// ==== design/VideoTxCsr.sv ====
// AXI4-Lite slave, full-word writes only, one request in flight per channel
// Master must hold its valid until the matching ready pulse
`timescale 1ns/10ps
`default_nettype none

module VideoTxCsr (
	input wire iVCLK,
	input wire iVRST,
	input wire [VideoCsrPkg::lpAxiAdrsW-1:0] axiAwAddr,
	input wire axiAwValid,
	output logic axiAwReady,
	input wire [VideoCsrPkg::lpAxiDataW-1:0] axiWData,
	input wire axiWValid,
	output logic axiWReady,
	output logic [1:0] axiBResp,
	output logic axiBValid,
	input wire axiBReady,
	input wire [VideoCsrPkg::lpAxiAdrsW-1:0] axiArAddr,
	input wire axiArValid,
	output logic axiArReady,
	output logic [VideoCsrPkg::lpAxiDataW-1:0] axiRData,
	output logic [1:0] axiRResp,
	output logic axiRValid,
	input wire axiRReady,
	input wire frameEnd,
	output logic videoEnable,
	output logic [VideoCsrPkg::lpColorW-1:0] bgColor,
	output logic [VideoCsrPkg::lpAxiDataW-1:0] rectBounds0,
	output logic [VideoCsrPkg::lpAxiDataW-1:0] rectBounds1,
	output logic [VideoCsrPkg::lpAxiDataW-1:0] rectBounds2,
	output logic [VideoCsrPkg::lpAxiDataW-1:0] rectBounds3,
	output logic [VideoCsrPkg::lpColorW-1:0] rectColor0,
	output logic [VideoCsrPkg::lpColorW-1:0] rectColor1,
	output logic [VideoCsrPkg::lpColorW-1:0] rectColor2,
	output logic [VideoCsrPkg::lpColorW-1:0] rectColor3
);
	import VideoCsrPkg::*;

	logic [lpAxiDataW-1:0] boundsReg [lpRectNum];
	logic [lpColorW-1:0] colorReg [lpRectNum];
	logic [lpFrameCntW-1:0] frameCnt;
	logic [lpAxiDataW-1:0] rdData;
	logic [lpRectIdxW-1:0] wrIdx, rdIdx;
	logic wrFire, rdFire, wrTake, rdTake;
	CsrSel wrSel, rdSel;

	function automatic CsrSel decodeSel(input logic [lpAxiAdrsW-1:0] adrs);
		CsrSel sel;
		sel = selNone;
		if (adrs == lpAdrsCtrl)
			sel = selCtrl;
		else if (adrs == lpAdrsBg)
			sel = selBg;
		else if (adrs == lpAdrsFrameCnt)
			sel = selFrameCnt;
		else if (adrs >= lpAdrsRectBase && adrs < lpAdrsRectBase + 8 * lpRectNum
				&& adrs[1:0] == 2'b00)
			sel = adrs[2] ? selColor : selBounds;	// Odd word holds the colour
		return sel;
	endfunction

	function automatic logic [lpRectIdxW-1:0] rectIdx(input logic [lpAxiAdrsW-1:0] adrs);
		logic [lpAxiAdrsW-1:0] off;
		off = adrs - lpAdrsRectBase;
		return off[lpRectIdxW+2:3];
	endfunction

	assign wrSel = decodeSel(axiAwAddr);
	assign rdSel = decodeSel(axiArAddr);
	assign wrIdx = rectIdx(axiAwAddr);
	assign rdIdx = rectIdx(axiArAddr);

	// --------------------------------------------------
	// Write channel
	// --------------------------------------------------
	assign wrTake = axiAwValid && axiWValid && !axiAwReady && !axiBValid;
	assign wrFire = axiAwValid && axiWValid && axiAwReady;	// Both readys move together

	always_ff @(posedge iVCLK)
	begin
		if (iVRST)
		begin
			axiAwReady <= 1'b0;
			axiWReady <= 1'b0;
			axiBValid <= 1'b0;
			axiBResp <= respOkay;
		end
		else
		begin
			axiAwReady <= wrTake;
			axiWReady <= wrTake;
			if (wrFire)
			begin
				axiBValid <= 1'b1;
				axiBResp <= (wrSel == selNone || wrSel == selFrameCnt) ? respSlvErr : respOkay;
			end
			else if (axiBReady)
				axiBValid <= 1'b0;
		end
	end

	always_ff @(posedge iVCLK)
	begin
		if (iVRST)
		begin
			videoEnable <= 1'b0;
			bgColor <= lpBgReset;
			for (int i = 0; i < lpRectNum; i++)
			begin
				boundsReg[i] <= lpBoundsReset;
				colorReg[i] <= lpRectColorReset;
			end
		end
		else if (wrFire)
		begin
			case (wrSel)
				selCtrl: videoEnable <= axiWData[0];
				selBg: bgColor <= axiWData[lpColorW-1:0];
				selBounds: boundsReg[wrIdx] <= axiWData;
				selColor: colorReg[wrIdx] <= axiWData[lpColorW-1:0];
				default: ;	// Frame count and holes ignore writes
			endcase
		end
	end

	always_ff @(posedge iVCLK)
	begin
		if (iVRST)
			frameCnt <= '0;
		else if (frameEnd)
			frameCnt <= frameCnt + 1'b1;	// Wraps
	end

	// --------------------------------------------------
	// Read channel
	// --------------------------------------------------
	always_comb
	begin
		case (rdSel)
			selCtrl: rdData = {{(lpAxiDataW-1){1'b0}}, videoEnable};
			selBg: rdData = {{(lpAxiDataW-lpColorW){1'b0}}, bgColor};
			selBounds: rdData = boundsReg[rdIdx];
			selColor: rdData = {{(lpAxiDataW-lpColorW){1'b0}}, colorReg[rdIdx]};
			selFrameCnt: rdData = {{(lpAxiDataW-lpFrameCntW){1'b0}}, frameCnt};
			default: rdData = '0;
		endcase
	end

	assign rdTake = axiArValid && !axiArReady && !axiRValid;
	assign rdFire = axiArValid && axiArReady;

	always_ff @(posedge iVCLK)
	begin
		if (iVRST)
		begin
			axiArReady <= 1'b0;
			axiRValid <= 1'b0;
			axiRResp <= respOkay;
		end
		else
		begin
			axiArReady <= rdTake;
			if (rdFire)
			begin
				axiRValid <= 1'b1;
				axiRResp <= (rdSel == selNone) ? respSlvErr : respOkay;
			end
			else if (axiRReady)
				axiRValid <= 1'b0;
		end
	end

	always_ff @(posedge iVCLK)
	begin
		if (rdFire)
			axiRData <= rdData;	// Held until the next accepted read
	end

	assign rectBounds0 = boundsReg[0];
	assign rectBounds1 = boundsReg[1];
	assign rectBounds2 = boundsReg[2];
	assign rectBounds3 = boundsReg[3];
	assign rectColor0 = colorReg[0];
	assign rectColor1 = colorReg[1];
	assign rectColor2 = colorReg[2];
	assign rectColor3 = colorReg[3];

endmodule

`default_nettype wire

// ==== design/VideoSyncGen.sv ====
// Free-running panel timing, one idle cycle after reset, then sync line 0
// All outputs stay low while held in reset
`timescale 1ns/10ps
`default_nettype none

module VideoSyncGen (
	input wire iVCLK,
	input wire iVRST,
	output logic hs,
	output logic vs,
	output logic de,
	output logic fe,
	output logic [VideoTimingPkg::lpPosW-1:0] hPos,
	output logic [VideoTimingPkg::lpPosW-1:0] vPos
);
	import VideoTimingPkg::*;

	SyncPhase hPhase, vPhase;
	logic [lpHCntW-1:0] hCnt;
	logic [lpVCntW-1:0] vCnt;
	logic genRun;
	logic hLast, vLast;

	// Length of a phase, same shape on both axes
	function automatic int phaseLen(input SyncPhase ph, input int s, input int b,
			input int a, input int f);
		case (ph)
			phSync: return s;
			phBack: return b;
			phActive: return a;
			default: return f;
		endcase
	endfunction

	function automatic SyncPhase nextPhase(input SyncPhase ph);
		case (ph)
			phSync: return phBack;
			phBack: return phActive;
			phActive: return phFront;
			default: return phSync;
		endcase
	endfunction

	assign hLast = (int'(hCnt) == phaseLen(hPhase, lpVHS, lpVHB, lpVHA, lpVHF) - 1);
	assign vLast = (int'(vCnt) == phaseLen(vPhase, lpVVS, lpVVB, lpVVA, lpVVF) - 1);

	always_ff @(posedge iVCLK)
	begin
		if (iVRST)
		begin
			genRun <= 1'b0;
			hPhase <= phSync;
			hCnt <= '0;
			vPhase <= phSync;
			vCnt <= '0;
		end
		else if (!genRun)
			genRun <= 1'b1;
		else
		begin
			hCnt <= hLast ? '0 : hCnt + 1'b1;
			if (hLast)
				hPhase <= nextPhase(hPhase);
			// Vertical steps at the end of each line
			if (hLast && hPhase == phFront)
			begin
				vCnt <= vLast ? '0 : vCnt + 1'b1;
				if (vLast)
					vPhase <= nextPhase(vPhase);
			end
		end
	end

	assign hs = genRun && hPhase == phSync;
	assign vs = genRun && vPhase == phSync;
	assign de = genRun && hPhase == phActive && vPhase == phActive;
	assign fe = genRun && hLast && vLast && hPhase == phFront && vPhase == phFront;
	assign hPos = (hPhase == phActive) ? lpPosW'(hCnt) : '0;	// Active pixel index
	assign vPos = (vPhase == phActive) ? lpPosW'(vCnt) : '0;

endmodule

`default_nettype wire

// ==== design/VideoPixelGen.sv ====
// Two-cycle rectangle renderer, lowest index wins, bounds inclusive
// Register values are used live, a change shows on the next pixel
`timescale 1ns/10ps
`default_nettype none

module VideoPixelGen (
	input wire iVCLK,
	input wire iVRST,
	input wire de,
	input wire [VideoTimingPkg::lpPosW-1:0] hPos,
	input wire [VideoTimingPkg::lpPosW-1:0] vPos,
	input wire [VideoCsrPkg::lpColorW-1:0] bgColor,
	input wire [VideoCsrPkg::lpAxiDataW-1:0] rectBounds0,
	input wire [VideoCsrPkg::lpAxiDataW-1:0] rectBounds1,
	input wire [VideoCsrPkg::lpAxiDataW-1:0] rectBounds2,
	input wire [VideoCsrPkg::lpAxiDataW-1:0] rectBounds3,
	input wire [VideoCsrPkg::lpColorW-1:0] rectColor0,
	input wire [VideoCsrPkg::lpColorW-1:0] rectColor1,
	input wire [VideoCsrPkg::lpColorW-1:0] rectColor2,
	input wire [VideoCsrPkg::lpColorW-1:0] rectColor3,
	output logic [VideoCsrPkg::lpColorW-1:0] pixColor
);
	import VideoTimingPkg::*;
	import VideoCsrPkg::*;

	logic [lpAxiDataW-1:0] bounds [lpRectNum];
	logic [lpColorW-1:0] colors [lpRectNum];
	logic [lpRectNum-1:0] hit, hitQ;
	logic deQ;
	logic [lpColorW-1:0] pickColor;

	assign bounds = '{rectBounds0, rectBounds1, rectBounds2, rectBounds3};
	assign colors = '{rectColor0, rectColor1, rectColor2, rectColor3};

	// --------------------------------------------------
	// Stage 1 hit test
	// --------------------------------------------------
	always_comb
	begin
		for (int i = 0; i < lpRectNum; i++)
		begin
			hit[i] = hPos >= bounds[i][31:24] && hPos <= bounds[i][23:16]	// Left, right
				&& vPos >= bounds[i][15:8] && vPos <= bounds[i][7:0];	// Top, under
		end
	end

	// Stage 2 priority select
	always_comb
	begin
		pickColor = bgColor;
		for (int i = lpRectNum - 1; i >= 0; i--)
		begin
			if (hitQ[i])
				pickColor = colors[i];
		end
	end

	always_ff @(posedge iVCLK)
	begin
		if (iVRST)
		begin
			hitQ <= '0;
			deQ <= 1'b0;
			pixColor <= '0;
		end
		else
		begin
			hitQ <= hit;
			deQ <= de;
			pixColor <= deQ ? pickColor : '0;	// Black outside the active area
		end
	end

endmodule

`default_nettype wire

// ==== design/VideoTxBlock.sv ====
// Video transmit top, single clock, pixels computed on the fly
// Sync gen waits a fixed count after reset and runs only while enabled
`timescale 1ns/10ps
`default_nettype none

module VideoTxBlock (
	input wire iVCLK,
	input wire iVRST,
	input wire [VideoCsrPkg::lpAxiAdrsW-1:0] axiAwAddr,
	input wire axiAwValid,
	output logic axiAwReady,
	input wire [VideoCsrPkg::lpAxiDataW-1:0] axiWData,
	input wire axiWValid,
	output logic axiWReady,
	output logic [1:0] axiBResp,
	output logic axiBValid,
	input wire axiBReady,
	input wire [VideoCsrPkg::lpAxiAdrsW-1:0] axiArAddr,
	input wire axiArValid,
	output logic axiArReady,
	output logic [VideoCsrPkg::lpAxiDataW-1:0] axiRData,
	output logic [1:0] axiRResp,
	output logic axiRValid,
	input wire axiRReady,
	output logic [7:0] videoR,
	output logic [7:0] videoG,
	output logic [7:0] videoB,
	output logic videoHs,
	output logic videoVs,
	output logic videoDe,
	output logic videoFe
);
	import VideoTimingPkg::*;
	import VideoCsrPkg::*;

	logic [lpRstWaitW-1:0] rstWaitCnt;
	logic rstWaitDone, syncRst, videoEnable;
	logic [lpColorW-1:0] bgColor, pixColor;
	logic [lpAxiDataW-1:0] rectBounds0, rectBounds1, rectBounds2, rectBounds3;
	logic [lpColorW-1:0] rectColor0, rectColor1, rectColor2, rectColor3;
	logic hs, vs, de, fe;
	logic [lpPosW-1:0] hPos, vPos;
	logic [lpPixLatency-1:0][3:0] syncPipe;	// {hs, vs, de, fe} per stage

	VideoTxCsr uCsr (.*, .frameEnd(videoFe));

	VideoSyncGen uSyncGen (.iVCLK, .iVRST(syncRst), .hs, .vs, .de, .fe, .hPos, .vPos);

	VideoPixelGen uPixelGen (.*);

	// --------------------------------------------------
	// Reset wait
	// --------------------------------------------------
	assign rstWaitDone = (rstWaitCnt == lpRstWaitW'(lpRstWait));
	assign syncRst = iVRST || !rstWaitDone || !videoEnable;

	always_ff @(posedge iVCLK)
	begin
		if (iVRST)
			rstWaitCnt <= '0;
		else if (!rstWaitDone)
			rstWaitCnt <= rstWaitCnt + 1'b1;	// Stops at lpRstWait
	end

	// Sync delay matching the pixel pipeline
	always_ff @(posedge iVCLK)
	begin
		if (iVRST)
			syncPipe <= '0;
		else
			syncPipe <= {syncPipe[lpPixLatency-2:0], {hs, vs, de, fe}};
	end

	assign {videoHs, videoVs, videoDe, videoFe} = syncPipe[lpPixLatency-1];
	assign videoR = pixColor[23:16];
	assign videoG = pixColor[15:8];
	assign videoB = pixColor[7:0];

endmodule

`default_nettype wire

// ==== tests/VideoTxBlock_props.sv ====
// Bound into the top level, response holding and sync exclusivity only
`timescale 1ns/10ps
`default_nettype none

module VideoTxBlockProps (
	input wire iVCLK,
	input wire iVRST,
	input wire axiBValid,
	input wire axiBReady,
	input wire axiRValid,
	input wire axiRReady,
	input wire [VideoCsrPkg::lpAxiDataW-1:0] axiRData,
	input wire videoDe,
	input wire videoHs
);

	int failCount = 0;	// Failed assertions so far

	// --------------------------------------------------
	// AXI responses held until taken
	// --------------------------------------------------
	bHoldProp: assert property (@(posedge iVCLK) disable iff (iVRST)
		axiBValid && !axiBReady |=> axiBValid)
	else
	begin
		failCount++;
		$error("axiBValid dropped before axiBReady");
	end

	rHoldProp: assert property (@(posedge iVCLK) disable iff (iVRST)
		axiRValid && !axiRReady |=> axiRValid && $stable(axiRData))
	else
	begin
		failCount++;
		$error("axiRValid or axiRData changed before axiRReady");
	end

	// Active video never inside horizontal sync
	deHsProp: assert property (@(posedge iVCLK) disable iff (iVRST)
		!(videoDe && videoHs))
	else
	begin
		failCount++;
		$error("videoDe high during videoHs");
	end

endmodule

bind VideoTxBlock VideoTxBlockProps uProps (.*);

`default_nettype wire

// ==== tests/VideoTxBlockTb.sv ====
// Register table over AXI4-Lite, then two checked frames and a disabled frame
// Inputs change 2 ns after the rising edge, outputs sampled on the falling edge
`timescale 1ns/10ps
`default_nettype none

module VideoTxBlockTb;
	import VideoTimingPkg::*;
	import VideoCsrPkg::*;

	localparam int lpRows = 12;
	localparam int lpFrameCycles = (lpVHS + lpVHB + lpVHA + lpVHF)
		* (lpVVS + lpVVB + lpVVA + lpVVF);
	localparam int lpTimeout = lpRstWait + 4 * lpFrameCycles + 20 * lpRows;

	// Address, write data, read data, write response, read response
	localparam logic [75:0] lpRegTable [lpRows] = '{
		{8'h00, 32'h0000_0000, 32'h0000_0000, respOkay, respOkay},
		{8'h04, 32'hFF12_3456, 32'h0012_3456, respOkay, respOkay},	// Upper byte dropped
		{8'h10, 32'h0207_0104, 32'h0207_0104, respOkay, respOkay},
		{8'h14, 32'h00AA_0000, 32'h00AA_0000, respOkay, respOkay},
		{8'h18, 32'h050C_0306, 32'h050C_0306, respOkay, respOkay},	// Overlaps rect 0
		{8'h1C, 32'h0000_BB00, 32'h0000_BB00, respOkay, respOkay},
		{8'h20, 32'h000F_0607, 32'h000F_0607, respOkay, respOkay},
		{8'h24, 32'h0000_00CC, 32'h0000_00CC, respOkay, respOkay},
		{8'h28, 32'h0A14_0002, 32'h0A14_0002, respOkay, respOkay},
		{8'h2C, 32'hDE65_4321, 32'h0065_4321, respOkay, respOkay},
		{8'h08, 32'h0000_0005, 32'h0000_0000, respSlvErr, respSlvErr},	// Hole
		{8'h40, 32'h0000_1234, 32'h0000_0000, respSlvErr, respOkay}	// Read-only
	};

	logic iVCLK, iVRST;
	logic [7:0] axiAwAddr, axiArAddr;
	logic [31:0] axiWData, axiRData;
	logic axiAwValid, axiAwReady, axiWValid, axiWReady, axiBValid, axiBReady;
	logic axiArValid, axiArReady, axiRValid, axiRReady;
	logic [1:0] axiBResp, axiRResp, resp;
	logic [7:0] videoR, videoG, videoB;
	logic videoHs, videoVs, videoDe, videoFe;
	logic [15:0] lfsr = 16'd54284;
	int cycleCnt = 0;
	int feCount;
	logic [75:0] row;
	logic [31:0] rdData, fcBefore;
	logic [23:0] mBg;	// Register model
	logic [31:0] mBounds [lpRectNum];
	logic [23:0] mColor [lpRectNum];

	VideoTxBlock u_dut (.*);

	always #20 iVCLK = ~iVCLK;

	always @(posedge iVCLK)
	begin
		cycleCnt <= cycleCnt + 1;
		if (cycleCnt >= lpTimeout)
		begin
			$display("Timeout after %0d cycles, DUT stopped responding", cycleCnt);
			$display(">>> FAIL");
			$fatal(1, "Run aborted on timeout");
		end
	end

	// Stop as soon as a bound assertion has failed
	always @(posedge iVCLK)
	begin
		if (u_dut.uProps.failCount != 0)
		begin
			$display("Bound assertion failed before %0t ns, see the error above", $time);
			$display(">>> FAIL");
			$fatal(1, "Run aborted on assertion failure");
		end
	end

	task automatic checkEq(input logic [31:0] got, input logic [31:0] exp, input string what);
		if (got !== exp)
		begin
			$display("[ERROR] %0t ns %s, got %0h expected %0h", $time, what, got, exp);
			$display(">>> FAIL");
			$fatal(1, "Stopped at first mismatch");
		end
	endtask

	// x^16 + x^14 + x^13 + x^11 + 1
	function automatic logic [15:0] lfsrNext(input logic [15:0] s);
		return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};
	endfunction

	task automatic drawStall(output int n);
		n = 0;
		for (int b = 0; b < 2; b++)
		begin
			lfsr = lfsrNext(lfsr);	// One step per bit
			n = n * 2 + lfsr[0];
		end
	endtask

	// --------------------------------------------------
	// AXI4-Lite master
	// --------------------------------------------------
	task automatic axiWrite(input logic [7:0] adrs, input logic [31:0] data,
			output logic [1:0] bResp);
		int stall;
		drawStall(stall);
		@(posedge iVCLK);
		#2;
		axiAwAddr = adrs;
		axiWData = data;
		axiAwValid = 1'b1;
		axiWValid = 1'b1;
		do @(negedge iVCLK); while (!axiAwReady);
		checkEq(axiWReady, 1'b1, "axiWReady with axiAwReady");
		@(posedge iVCLK);
		#2;
		axiAwValid = 1'b0;
		axiWValid = 1'b0;
		do @(negedge iVCLK); while (!axiBValid);
		repeat (stall) @(negedge iVCLK);	// Response must hold here
		bResp = axiBResp;
		@(posedge iVCLK);
		#2 axiBReady = 1'b1;
		@(posedge iVCLK);
		#2 axiBReady = 1'b0;
	endtask

	task automatic axiRead(input logic [7:0] adrs, output logic [31:0] data,
			output logic [1:0] rResp);
		int stall;
		drawStall(stall);
		@(posedge iVCLK);
		#2;
		axiArAddr = adrs;
		axiArValid = 1'b1;
		do @(negedge iVCLK); while (!axiArReady);
		@(posedge iVCLK);
		#2 axiArValid = 1'b0;
		do @(negedge iVCLK); while (!axiRValid);
		repeat (stall) @(negedge iVCLK);
		data = axiRData;
		rResp = axiRResp;
		@(posedge iVCLK);
		#2 axiRReady = 1'b1;
		@(posedge iVCLK);
		#2 axiRReady = 1'b0;
	endtask

	task automatic updateModel(input logic [7:0] adrs, input logic [31:0] data);
		int n;
		n = int'(adrs >> 3) - 2;	// Rectangle index from 0x10 + 8n
		if (adrs == 8'h04)
			mBg = data[23:0];
		else if (adrs >= 8'h10 && adrs < 8'h30 && adrs[1:0] == 2'b00)
		begin
			if (adrs[2])
				mColor[n] = data[23:0];
			else
				mBounds[n] = data;
		end
	endtask

	// Lowest index wins, bounds inclusive
	function automatic logic [23:0] expPixel(input int x, input int y);
		logic [23:0] c;
		c = mBg;
		for (int i = lpRectNum - 1; i >= 0; i--)
		begin
			if (x >= mBounds[i][31:24] && x <= mBounds[i][23:16]
					&& y >= mBounds[i][15:8] && y <= mBounds[i][7:0])
				c = mColor[i];
		end
		return c;
	endfunction

	// --------------------------------------------------
	// Frame checker, starts at the next rising videoVs
	// --------------------------------------------------
	task automatic checkFrames(input int nFrames, output int feSeen);
		int cycles, deLines, x, hsLen;
		logic prevVs, prevDe, prevHs;
		feSeen = 0;
		do @(negedge iVCLK); while (!videoVs);
		for (int f = 0; f < nFrames; f++)
		begin
			cycles = 0;
			deLines = 0;
			x = 0;
			hsLen = 0;
			prevDe = 1'b0;
			prevHs = 1'b0;
			do
			begin
				cycles++;
				if (videoHs)
					hsLen++;
				else if (prevHs)
				begin
					checkEq(hsLen, lpVHS, "hsync width");
					hsLen = 0;
				end
				if (videoDe && !prevDe)
				begin
					deLines++;
					x = 0;
				end
				if (videoDe)
				begin
					checkEq({videoR, videoG, videoB}, expPixel(x, deLines - 1),
						$sformatf("pixel colour at (%0d,%0d)", x, deLines - 1));
					x++;
				end
				else
				begin
					if (prevDe)
						checkEq(x, lpVHA, "de width");
					checkEq({videoR, videoG, videoB}, 0, "blanking colour");
				end
				if (videoFe)
					feSeen++;
				prevVs = videoVs;
				prevDe = videoDe;
				prevHs = videoHs;
				@(negedge iVCLK);
			end
			while (!(videoVs && !prevVs));
			checkEq(cycles, lpFrameCycles, "frame length");
			checkEq(deLines, lpVVA, "active lines per frame");
		end
	endtask

	initial
	begin
		iVCLK = 1'b0;
		iVRST = 1'b1;
		axiAwAddr = '0;
		axiAwValid = 1'b0;
		axiWData = '0;
		axiWValid = 1'b0;
		axiBReady = 1'b0;
		axiArAddr = '0;
		axiArValid = 1'b0;
		axiRReady = 1'b0;
		mBg = '0;
		for (int i = 0; i < lpRectNum; i++)
		begin
			mBounds[i] = '0;
			mColor[i] = '0;
		end
		repeat (2) @(posedge iVCLK);
		#2 iVRST = 1'b0;
		@(negedge iVCLK);
		checkEq({videoR, videoG, videoB, videoHs, videoVs, videoDe, videoFe}, 0,
			"video after reset");
		checkEq({axiAwReady, axiWReady, axiArReady, axiBValid, axiRValid}, 0,
			"AXI after reset");
		axiRead(lpAdrsCtrl, rdData, resp);
		checkEq(rdData, 0, "control after reset");
		checkEq(resp, respOkay, "control read response");

		for (int r = 0; r < lpRows; r++)
		begin
			row = lpRegTable[r];
			axiWrite(row[75:68], row[67:36], resp);
			checkEq(resp, row[3:2], $sformatf("write response at %02h", row[75:68]));
			if (row[3:2] == respOkay)
				updateModel(row[75:68], row[67:36]);
			axiRead(row[75:68], rdData, resp);
			checkEq(rdData, row[35:4], $sformatf("read data at %02h", row[75:68]));
			checkEq(resp, row[1:0], $sformatf("read response at %02h", row[75:68]));
		end

		// Enable and watch two full frames
		axiRead(lpAdrsFrameCnt, fcBefore, resp);
		fork
			axiWrite(lpAdrsCtrl, 32'h1, resp);
			checkFrames(2, feCount);
		join
		checkEq(feCount, 2, "frame end pulses");
		axiRead(lpAdrsFrameCnt, rdData, resp);
		checkEq(rdData, fcBefore + 2, "frame count");

		axiWrite(lpAdrsCtrl, 32'h0, resp);
		repeat (lpPixLatency + 2) @(posedge iVCLK);	// Flush the sync delay
		repeat (lpFrameCycles)
		begin
			@(negedge iVCLK);
			checkEq({videoDe, videoHs, videoVs}, 0, "sync while disabled");
		end
		if (u_dut.uProps.failCount != 0)
		begin
			$display("Bound assertion failed, see the error above");
			$display(">>> FAIL");
			$fatal(1, "Run aborted on assertion failure");
		end
		else
		begin
			$display(">>> PASS");
			$finish;
		end
	end

endmodule

`default_nettype wire

// ==== filelist.f ====
design/VideoTimingPkg.sv
design/VideoCsrPkg.sv
design/VideoTxCsr.sv
design/VideoSyncGen.sv
design/VideoPixelGen.sv
design/VideoTxBlock.sv
tests/VideoTxBlock_props.sv
tests/VideoTxBlockTb.sv
